// File: verilog/udma_rx_pkg.sv
//--------------------------------------------------------------------------
// shared widths, register map and bus types of the receive subsystem
// only full 32-bit words are moved, so sizes and addresses are word based
// every channel owns a 16-byte register window starting at offset 0x00
//--------------------------------------------------------------------------
package udma_rx_pkg;

    localparam int N_RX_CHANNELS  = 2;
    localparam int CH_IDX_WIDTH   = (N_RX_CHANNELS > 1) ? $clog2(N_RX_CHANNELS) : 1;

    localparam int L2_ADDR_WIDTH  = 15;                // word address
    localparam int L2_AWIDTH_NOAL = L2_ADDR_WIDTH + 2; // byte address
    localparam int TRANS_SIZE     = 17;
    localparam int DATA_WIDTH     = 32;
    localparam int L2_BE_WIDTH    = DATA_WIDTH / 8;
    localparam int APB_ADDR_WIDTH = 12;

    localparam logic [7:0] L2_BASE_PREFIX = 8'h1C;

    // offsets inside one channel window
    localparam logic [3:0] REG_SADDR = 4'h0; // reads current address
    localparam logic [3:0] REG_SIZE  = 4'h4; // reads bytes left
    localparam logic [3:0] REG_CFG   = 4'h8;

    localparam int CFG_CONT_BIT = 0;
    localparam int CFG_EN_BIT   = 4;
    localparam int CFG_CLR_BIT  = 5;

    typedef struct packed {
        logic [L2_AWIDTH_NOAL-1:0] startaddr;
        logic [TRANS_SIZE-1:0]     size;
        logic                      continuous;
        logic                      en;         // one-cycle start
        logic                      clr;        // one-cycle stop
    } rx_cfg_t;

    typedef struct packed {
        logic                      active;
        logic [L2_AWIDTH_NOAL-1:0] curr_addr;
        logic [TRANS_SIZE-1:0]     bytes_left;
    } rx_status_t;

    typedef struct packed {
        logic [L2_AWIDTH_NOAL-1:0] addr;
        logic [DATA_WIDTH-1:0]     data;
    } l2_wreq_t;

endpackage

// File: verilog/udma_rx_apb_regs.sv
//--------------------------------------------------------------------------
// APB register file for the receive channels, no wait states
// sizes are stored word aligned, enable is ignored while size is zero
// reserved offsets and missing channels answer with PSLVERR and zero data
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module udma_rx_apb_regs (
    input  logic                                       sys_clk_i,
    input  logic                                       arst_n_i,
    input  logic [udma_rx_pkg::APB_ADDR_WIDTH-1:0]     paddr_i,
    input  logic [31:0]                                pwdata_i,
    input  logic                                       pwrite_i,
    input  logic                                       psel_i,
    input  logic                                       penable_i,
    output logic [31:0]                                prdata_o,
    output logic                                       pready_o,
    output logic                                       pslverr_o,
    input  udma_rx_pkg::rx_status_t [udma_rx_pkg::N_RX_CHANNELS-1:0] status_i,
    output udma_rx_pkg::rx_cfg_t    [udma_rx_pkg::N_RX_CHANNELS-1:0] cfg_o
);

    logic [udma_rx_pkg::APB_ADDR_WIDTH-5:0] ch_sel;
    logic [udma_rx_pkg::CH_IDX_WIDTH-1:0]   ch_idx;
    logic [3:0]                             offset;
    logic                                   hit;
    logic                                   wr;
    logic                                   cfg_wr;

    logic [udma_rx_pkg::N_RX_CHANNELS-1:0][udma_rx_pkg::L2_AWIDTH_NOAL-1:0] startaddr_q;
    logic [udma_rx_pkg::N_RX_CHANNELS-1:0][udma_rx_pkg::TRANS_SIZE-1:0]     size_q;
    logic [udma_rx_pkg::N_RX_CHANNELS-1:0]                                  cont_q;

    assign ch_sel = paddr_i[udma_rx_pkg::APB_ADDR_WIDTH-1:4];
    assign ch_idx = ch_sel[udma_rx_pkg::CH_IDX_WIDTH-1:0];
    assign offset = paddr_i[3:0];

    assign hit = (ch_sel < udma_rx_pkg::N_RX_CHANNELS) &&
                 (offset inside {udma_rx_pkg::REG_SADDR, udma_rx_pkg::REG_SIZE,
                                 udma_rx_pkg::REG_CFG});

    assign wr        = psel_i & penable_i & pwrite_i & hit;
    assign cfg_wr    = wr && (offset == udma_rx_pkg::REG_CFG);
    assign pready_o  = 1'b1;
    assign pslverr_o = psel_i & penable_i & ~hit;

    always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            startaddr_q <= '0;
            size_q      <= '0;
            cont_q      <= '0;
        end else if (wr) begin
            case (offset)
                udma_rx_pkg::REG_SADDR:
                    startaddr_q[ch_idx] <= pwdata_i[udma_rx_pkg::L2_AWIDTH_NOAL-1:0];
                udma_rx_pkg::REG_SIZE:
                    size_q[ch_idx] <= {pwdata_i[udma_rx_pkg::TRANS_SIZE-1:2], 2'b00};
                udma_rx_pkg::REG_CFG: begin
                    cont_q[ch_idx] <= pwdata_i[udma_rx_pkg::CFG_CONT_BIT];
                    if (pwdata_i[udma_rx_pkg::CFG_CLR_BIT]) begin
                        size_q[ch_idx] <= '0; // cleared buffer reads back empty
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        for (int c = 0; c < udma_rx_pkg::N_RX_CHANNELS; c++) begin
            cfg_o[c].startaddr  = startaddr_q[c];
            cfg_o[c].size       = size_q[c];
            cfg_o[c].continuous = cont_q[c];
            cfg_o[c].en         = cfg_wr && (ch_idx == udma_rx_pkg::CH_IDX_WIDTH'(c)) &&
                                  pwdata_i[udma_rx_pkg::CFG_EN_BIT] && (size_q[c] != '0);
            cfg_o[c].clr        = cfg_wr && (ch_idx == udma_rx_pkg::CH_IDX_WIDTH'(c)) &&
                                  pwdata_i[udma_rx_pkg::CFG_CLR_BIT];
        end
    end

    // live counters while running, programmed values otherwise
    always_comb begin
        prdata_o = '0;
        if (hit) begin
            case (offset)
                udma_rx_pkg::REG_SADDR:
                    prdata_o = status_i[ch_idx].active ? 32'(status_i[ch_idx].curr_addr)
                                                       : 32'(startaddr_q[ch_idx]);
                udma_rx_pkg::REG_SIZE:
                    prdata_o = status_i[ch_idx].active ? 32'(status_i[ch_idx].bytes_left)
                                                       : 32'(size_q[ch_idx]);
                udma_rx_pkg::REG_CFG: begin
                    prdata_o[udma_rx_pkg::CFG_CONT_BIT] = cont_q[ch_idx];
                    prdata_o[udma_rx_pkg::CFG_EN_BIT]   = status_i[ch_idx].active;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: verilog/udma_rx_channel.sv
//--------------------------------------------------------------------------
// address and byte counter of one receive channel
// clear beats start, and start beats a grant in the same cycle
// the event marks acceptance of the last word, not its L2 write
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module udma_rx_channel (
    input  logic                    sys_clk_i,
    input  logic                    arst_n_i,
    input  udma_rx_pkg::rx_cfg_t    cfg_i,
    input  logic                    grant_i,
    output udma_rx_pkg::rx_status_t status_o,
    output logic                    eot_o
);

    logic                                   active_q;
    logic [udma_rx_pkg::L2_AWIDTH_NOAL-1:0] curr_addr_q;
    logic [udma_rx_pkg::TRANS_SIZE-1:0]     bytes_left_q;
    logic                                   last_word;

    assign last_word = (bytes_left_q == udma_rx_pkg::TRANS_SIZE'(4));

    always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            active_q     <= 1'b0;
            curr_addr_q  <= '0;
            bytes_left_q <= '0;
            eot_o        <= 1'b0;
        end else begin
            eot_o <= 1'b0;
            if (cfg_i.clr) begin
                active_q     <= 1'b0;
                bytes_left_q <= '0;
            end else if (cfg_i.en) begin
                active_q     <= 1'b1;
                curr_addr_q  <= cfg_i.startaddr;
                bytes_left_q <= cfg_i.size;
            end else if (grant_i) begin
                curr_addr_q  <= curr_addr_q + udma_rx_pkg::L2_AWIDTH_NOAL'(4);
                bytes_left_q <= bytes_left_q - udma_rx_pkg::TRANS_SIZE'(4);
                if (last_word) begin
                    eot_o <= 1'b1;
                    if (cfg_i.continuous) begin
                        curr_addr_q  <= cfg_i.startaddr; // next pass
                        bytes_left_q <= cfg_i.size;
                    end else begin
                        active_q <= 1'b0;
                    end
                end
            end
        end
    end

    assign status_o.active     = active_q;
    assign status_o.curr_addr  = curr_addr_q;
    assign status_o.bytes_left = bytes_left_q;

endmodule

// File: verilog/udma_rx_arbiter.sv
//--------------------------------------------------------------------------
// round-robin pick among active channels with valid data
// one word slot in front of the L2 port, refilled in the cycle it empties
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module udma_rx_arbiter (
    input  logic                                                    sys_clk_i,
    input  logic                                                    arst_n_i,
    input  logic [udma_rx_pkg::N_RX_CHANNELS-1:0]                   rx_valid_i,
    input  logic [udma_rx_pkg::N_RX_CHANNELS-1:0][udma_rx_pkg::DATA_WIDTH-1:0] rx_data_i,
    input  udma_rx_pkg::rx_status_t [udma_rx_pkg::N_RX_CHANNELS-1:0] status_i,
    input  logic                                                    port_free_i,
    output logic [udma_rx_pkg::N_RX_CHANNELS-1:0]                   rx_ready_o,
    output logic [udma_rx_pkg::N_RX_CHANNELS-1:0]                   grant_o,
    output udma_rx_pkg::l2_wreq_t                                   wreq_o,
    output logic                                                    wreq_valid_o
);

    logic [udma_rx_pkg::N_RX_CHANNELS-1:0] req;
    logic [udma_rx_pkg::N_RX_CHANNELS-1:0] take_vec;
    logic [udma_rx_pkg::CH_IDX_WIDTH-1:0]  rr_q;
    logic [udma_rx_pkg::CH_IDX_WIDTH-1:0]  pick;
    logic                                  found;
    logic                                  slot_open;
    logic                                  take;
    logic                                  slot_valid_q;
    udma_rx_pkg::l2_wreq_t                 slot_q;

    // search starts one past the last winner
    always_comb begin
        found = 1'b0;
        pick  = rr_q;
        for (int c = 0; c < udma_rx_pkg::N_RX_CHANNELS; c++) begin
            req[c] = rx_valid_i[c] & status_i[c].active;
        end
        for (int k = 1; k <= udma_rx_pkg::N_RX_CHANNELS; k++) begin
            if (!found && req[(int'(rr_q) + k) % udma_rx_pkg::N_RX_CHANNELS]) begin
                found = 1'b1;
                pick  = udma_rx_pkg::CH_IDX_WIDTH'((int'(rr_q) + k) %
                                                   udma_rx_pkg::N_RX_CHANNELS);
            end
        end
    end

    assign slot_open = ~slot_valid_q | port_free_i;
    assign take      = found & slot_open;

    always_comb begin
        take_vec = '0;
        if (take) begin
            take_vec[pick] = 1'b1;
        end
    end

    assign rx_ready_o = take_vec;
    assign grant_o    = take_vec; // steps the channel counters

    always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slot_valid_q <= 1'b0;
            rr_q         <= '0;
        end else if (take) begin
            slot_valid_q <= 1'b1;
            rr_q         <= pick;
        end else if (port_free_i) begin
            slot_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (take) begin
            slot_q.addr <= status_i[pick].curr_addr;
            slot_q.data <= rx_data_i[pick];
        end
    end

    assign wreq_o       = slot_q;
    assign wreq_valid_o = slot_valid_q;

endmodule

// File: verilog/udma_rx_l2_port.sv
//--------------------------------------------------------------------------
// L2 write-only port, request held with stable address and data until gnt
// full-word writes only, byte enables all set
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module udma_rx_l2_port (
    input  logic                                 sys_clk_i,
    input  logic                                 arst_n_i,
    input  udma_rx_pkg::l2_wreq_t                wreq_i,
    input  logic                                 wreq_valid_i,
    input  logic                                 l2_gnt_i,
    output logic                                 port_free_o,
    output logic                                 l2_req_o,
    output logic [31:0]                          l2_addr_o,
    output logic [udma_rx_pkg::DATA_WIDTH-1:0]   l2_wdata_o,
    output logic [udma_rx_pkg::L2_BE_WIDTH-1:0]  l2_be_o,
    output logic                                 l2_wen_o
);

    logic                  req_q;
    udma_rx_pkg::l2_wreq_t wreq_q;

    assign port_free_o = ~req_q | l2_gnt_i; // empty or emptied this cycle

    always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q <= 1'b0;
        end else if (port_free_o) begin
            req_q <= wreq_valid_i;
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (port_free_o && wreq_valid_i) begin
            wreq_q <= wreq_i;
        end
    end

    assign l2_req_o   = req_q;
    assign l2_addr_o  = {udma_rx_pkg::L2_BASE_PREFIX,
                         {(32 - udma_rx_pkg::L2_ADDR_WIDTH - 10){1'b0}},
                         wreq_q.addr[udma_rx_pkg::L2_AWIDTH_NOAL-1:2], 2'b00};
    assign l2_wdata_o = wreq_q.data;
    assign l2_be_o    = '1;
    assign l2_wen_o   = 1'b0; // low means write

endmodule

// File: verilog/udma_rx_subsystem.sv
//--------------------------------------------------------------------------
// receive subsystem top: APB registers, channel counters, arbiter, L2 port
// single clock domain, one event bit per channel on events_o
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module udma_rx_subsystem (
    input  logic                                                    sys_clk_i,
    input  logic                                                    arst_n_i,

    input  logic [udma_rx_pkg::APB_ADDR_WIDTH-1:0]                  paddr_i,
    input  logic [31:0]                                             pwdata_i,
    input  logic                                                    pwrite_i,
    input  logic                                                    psel_i,
    input  logic                                                    penable_i,
    output logic [31:0]                                             prdata_o,
    output logic                                                    pready_o,
    output logic                                                    pslverr_o,

    input  logic [udma_rx_pkg::N_RX_CHANNELS-1:0]                   rx_valid_i,
    input  logic [udma_rx_pkg::N_RX_CHANNELS-1:0][udma_rx_pkg::DATA_WIDTH-1:0] rx_data_i,
    output logic [udma_rx_pkg::N_RX_CHANNELS-1:0]                   rx_ready_o,

    output logic                                                    l2_req_o,
    input  logic                                                    l2_gnt_i,
    output logic [31:0]                                             l2_addr_o,
    output logic [udma_rx_pkg::DATA_WIDTH-1:0]                      l2_wdata_o,
    output logic [udma_rx_pkg::L2_BE_WIDTH-1:0]                     l2_be_o,
    output logic                                                    l2_wen_o,

    output logic [udma_rx_pkg::N_RX_CHANNELS-1:0]                   events_o
);

    udma_rx_pkg::rx_cfg_t    [udma_rx_pkg::N_RX_CHANNELS-1:0] s_cfg;
    udma_rx_pkg::rx_status_t [udma_rx_pkg::N_RX_CHANNELS-1:0] s_status;
    logic [udma_rx_pkg::N_RX_CHANNELS-1:0]                    s_grant;
    udma_rx_pkg::l2_wreq_t                                    s_wreq;
    logic                                                     s_wreq_valid;
    logic                                                     s_port_free;

    udma_rx_apb_regs u_regs (
        .sys_clk_i ( sys_clk_i ),
        .arst_n_i  ( arst_n_i  ),
        .paddr_i   ( paddr_i   ),
        .pwdata_i  ( pwdata_i  ),
        .pwrite_i  ( pwrite_i  ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .pslverr_o ( pslverr_o ),
        .status_i  ( s_status  ),
        .cfg_o     ( s_cfg     )
    );

    for (genvar g = 0; g < udma_rx_pkg::N_RX_CHANNELS; g++) begin : gen_channel
        udma_rx_channel u_channel (
            .sys_clk_i ( sys_clk_i   ),
            .arst_n_i  ( arst_n_i    ),
            .cfg_i     ( s_cfg[g]    ),
            .grant_i   ( s_grant[g]  ),
            .status_o  ( s_status[g] ),
            .eot_o     ( events_o[g] ) // event bit g is channel g
        );
    end

    udma_rx_arbiter u_arbiter (
        .sys_clk_i    ( sys_clk_i    ),
        .arst_n_i     ( arst_n_i     ),
        .rx_valid_i   ( rx_valid_i   ),
        .rx_data_i    ( rx_data_i    ),
        .status_i     ( s_status     ),
        .port_free_i  ( s_port_free  ),
        .rx_ready_o   ( rx_ready_o   ),
        .grant_o      ( s_grant      ),
        .wreq_o       ( s_wreq       ),
        .wreq_valid_o ( s_wreq_valid )
    );

    udma_rx_l2_port u_l2_port (
        .sys_clk_i    ( sys_clk_i    ),
        .arst_n_i     ( arst_n_i     ),
        .wreq_i       ( s_wreq       ),
        .wreq_valid_i ( s_wreq_valid ),
        .l2_gnt_i     ( l2_gnt_i     ),
        .port_free_o  ( s_port_free  ),
        .l2_req_o     ( l2_req_o     ),
        .l2_addr_o    ( l2_addr_o    ),
        .l2_wdata_o   ( l2_wdata_o   ),
        .l2_be_o      ( l2_be_o      ),
        .l2_wen_o     ( l2_wen_o     )
    );

endmodule

// File: verification/tb_udma_rx_model.svh
//--------------------------------------------------------------------------
// reference model queues, APB access and checks for the testbench module
// expected L2 writes are matched to grants in acceptance order
// channel c buffers are placed in the 64 KiB region at c * 0x10000
//--------------------------------------------------------------------------
`ifndef TB_UDMA_RX_MODEL_SVH
`define TB_UDMA_RX_MODEL_SVH

logic [63:0] exp_q[NCH][$];  // {l2 address, data}
int          order_q[$];     // channel of each accepted word
logic        m_active[NCH] = '{default: 1'b0};
logic        ev_due[NCH]   = '{default: 1'b0};
logic        m_cont[NCH];
logic [31:0] m_start[NCH];
logic [31:0] m_size[NCH];
logic [31:0] m_addr[NCH];
logic [31:0] m_left[NCH];
int          ev_seen[NCH];
int          acc_cnt[NCH];
int          wr_cnt[NCH];
int          test_errors;
string       test_name;

task automatic check_value(input string what, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    assert (act_v === exp_v) else begin
        $display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp_v, act_v);
        test_errors++;
    end
endtask

// one APB transfer with read data and error sampled in the access phase
task automatic apb_access(input logic wr, input int addr, input logic [31:0] data);
    @(posedge sys_clk);
    psel   <= 1'b1;
    pwrite <= wr;
    paddr  <= udma_rx_pkg::APB_ADDR_WIDTH'(addr);
    pwdata <= data;
    @(posedge sys_clk);
    penable <= 1'b1;
    @(negedge sys_clk);
    rdata = prdata;
    rerr  = pslverr;
    check_value("pready_o", 1, 32'(pready));
    @(posedge sys_clk); // write lands on this edge
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

task automatic program_channel(input int c, input int max_words);
    m_start[c] = 32'(c) * 32'h1_0000 + 32'(cfg_rand(0, 'h3F00)) * 4;
    m_size[c]  = 32'(cfg_rand(max_words / 2, max_words)) * 4;
    apb_access(1'b1, c * 16, m_start[c]);
    apb_access(1'b1, c * 16 + 4, m_size[c]);
endtask

task automatic set_cfg(input int c, input logic [31:0] data);
    apb_access(1'b1, c * 16 + 8, data);
    if (data[5]) begin
        m_active[c] = 1'b0;
        m_left[c]   = 0;
    end else if (data[4]) begin
        m_active[c] = 1'b1;
        m_cont[c]   = data[0];
        m_addr[c]   = m_start[c];
        m_left[c]   = m_size[c];
    end
endtask

task automatic model_accept(input int c, input logic [31:0] data);
    exp_q[c].push_back({32'h1C00_0000 | (m_addr[c] & 32'h0001_FFFC), data});
    order_q.push_back(c);
    acc_cnt[c]++;
    m_addr[c] = m_addr[c] + 4;
    m_left[c] = m_left[c] - 4;
    if (m_left[c] == 0) begin
        ev_due[c]   = 1'b1;  // end of pass
        m_active[c] = m_cont[c];
        m_addr[c]   = m_start[c];
        m_left[c]   = m_cont[c] ? m_size[c] : 0;
    end
endtask

task automatic model_write();
    int          c;
    logic [63:0] exp_w;
    if (order_q.size() == 0) begin
        $display("ERROR in %s: L2 write at %h with no accepted word pending", test_name, l2_addr);
        test_errors++;
    end else begin
        c     = order_q.pop_front();
        exp_w = exp_q[c].pop_front();
        check_value("l2_addr_o", exp_w[63:32], l2_addr);
        check_value("l2_wdata_o", exp_w[31:0], l2_wdata);
        check_value("l2_be_o", 32'hF, 32'(l2_be));
        check_value("l2_wen_o", 0, 32'(l2_wen));
        wr_cnt[c]++;
    end
endtask

`endif

// File: verification/tb_udma_rx_subsystem.sv
//--------------------------------------------------------------------------
// random-stimulus testbench of the receive subsystem with a queue model
// assumes two channels and word-aligned buffers below 64 KiB per channel
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module tb_udma_rx_subsystem;

    localparam int          NCH            = udma_rx_pkg::N_RX_CHANNELS;
    localparam logic [31:0] SEED           = 32'd41311;
    localparam int          WORD_BUDGET    = 200;  // upper bound on words over all tests
    localparam int          CYC_PER_WORD   = 12;   // valid gaps plus grant stalls
    localparam int          TIMEOUT_CYCLES = WORD_BUDGET * CYC_PER_WORD + 1000;

    logic                                  sys_clk;
    logic                                  arst_n;
    logic [udma_rx_pkg::APB_ADDR_WIDTH-1:0] paddr;
    logic [31:0]                           pwdata;
    logic                                  pwrite;
    logic                                  psel;
    logic                                  penable;
    logic [31:0]                           prdata;
    logic                                  pready;
    logic                                  pslverr;
    logic [NCH-1:0]                        rx_valid;
    logic [NCH-1:0][31:0]                  rx_data;
    logic [NCH-1:0]                        rx_ready;
    logic                                  l2_req;
    logic                                  l2_gnt;
    logic [31:0]                           l2_addr;
    logic [31:0]                           l2_wdata;
    logic [3:0]                            l2_be;
    logic                                  l2_wen;
    logic [NCH-1:0]                        events;

    logic [NCH-1:0] feed_on;
    logic [NCH-1:0] took;
    logic           gaps_on;
    logic           stalls_on;
    logic [31:0]    st_cfg;
    logic [31:0]    st_stream;
    logic [31:0]    rdata;
    logic           rerr;
    int             cycles;
    int             errors;
    int             tests_run;
    int             tests_failed;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int cfg_rand(input int lo, input int hi);
        st_cfg = lcg_step(st_cfg);
        return lo + int'(st_cfg[31:12] % (hi - lo + 1));
    endfunction

    `include "tb_udma_rx_model.svh"

    udma_rx_subsystem i_udma_rx_subsystem (
        .sys_clk_i  ( sys_clk  ),
        .arst_n_i   ( arst_n   ),
        .paddr_i    ( paddr    ),
        .pwdata_i   ( pwdata   ),
        .pwrite_i   ( pwrite   ),
        .psel_i     ( psel     ),
        .penable_i  ( penable  ),
        .prdata_o   ( prdata   ),
        .pready_o   ( pready   ),
        .pslverr_o  ( pslverr  ),
        .rx_valid_i ( rx_valid ),
        .rx_data_i  ( rx_data  ),
        .rx_ready_o ( rx_ready ),
        .l2_req_o   ( l2_req   ),
        .l2_gnt_i   ( l2_gnt   ),
        .l2_addr_o  ( l2_addr  ),
        .l2_wdata_o ( l2_wdata ),
        .l2_be_o    ( l2_be    ),
        .l2_wen_o   ( l2_wen   ),
        .events_o   ( events   )
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    // peripheral words and L2 grants from one random stream
    always @(posedge sys_clk) begin
        for (int c = 0; c < NCH; c++) begin
            if (!feed_on[c]) begin
                rx_valid[c] <= 1'b0;
            end else if (took[c] || !rx_valid[c]) begin
                st_stream = lcg_step(st_stream);
                rx_valid[c] <= !(gaps_on && st_stream[27]);
                rx_data[c]  <= st_stream;
            end
        end
        st_stream = lcg_step(st_stream);
        l2_gnt <= !(stalls_on && st_stream[29]);
    end

    always @(negedge sys_clk) begin
        if (arst_n) begin
            for (int c = 0; c < NCH; c++) begin
                check_value($sformatf("events_o[%0d]", c), 32'(ev_due[c]), 32'(events[c]));
                ev_seen[c] += int'(events[c]);
                ev_due[c]   = 1'b0;
                took[c]     = rx_valid[c] & rx_ready[c];
                assert (!rx_ready[c] || (m_active[c] && rx_valid[c])) else begin
                    $display("ERROR in %s: channel %0d ready with no word due", test_name, c);
                    test_errors++;
                end
                if (took[c]) begin
                    model_accept(c, rx_data[c]);
                end
            end
            if (l2_req && l2_gnt) begin
                model_write();
            end
        end
    end

    always @(posedge sys_clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic feed(input int c, input logic on);
        @(negedge sys_clk);
        feed_on[c] = on;
    endtask

    task automatic clear_counts();
        for (int c = 0; c < NCH; c++) begin
            ev_seen[c] = 0;
            acc_cnt[c] = 0;
            wr_cnt[c]  = 0;
        end
    endtask

    task automatic wait_drained();
        while (order_q.size() != 0) @(posedge sys_clk);
        repeat (4) @(posedge sys_clk);
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %-7s pass", test_name);
        end else begin
            $display("test %-7s fail, %0d errors", test_name, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        arst_n    = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        rx_valid  = '0;
        rx_data   = '0;
        l2_gnt    = 1'b0;
        feed_on   = '0;
        took      = '0;
        gaps_on   = 1'b0;
        stalls_on = 1'b0;
        st_cfg    = SEED;
        st_stream = lcg_step(SEED);
        repeat (2) @(posedge sys_clk);
        arst_n <= 1'b1;

        test_name = "reset";
        @(negedge sys_clk);
        check_value("l2_req_o", 0, 32'(l2_req));
        check_value("rx_ready_o", 0, 32'(rx_ready));
        check_value("events_o", 0, 32'(events));
        for (int c = 0; c < NCH; c++) begin
            apb_access(1'b0, c * 16 + 8, 0);
            check_value("REG_CFG", 0, rdata);
        end
        end_test();

        test_name = "regs";
        program_channel(0, 16);
        program_channel(1, 8);
        for (int c = 0; c < NCH; c++) begin
            apb_access(1'b0, c * 16, 0);
            check_value("REG_SADDR", m_start[c], rdata);
            apb_access(1'b0, c * 16 + 4, 0);
            check_value("REG_SIZE", m_size[c], rdata);
            check_value("pslverr_o", 0, 32'(rerr));
        end
        apb_access(1'b0, 'h00C, 0);  // reserved offset
        check_value("pslverr_o", 1, 32'(rerr));
        check_value("prdata_o", 0, rdata);
        end_test();

        test_name = "single";
        set_cfg(0, 32'h10);
        feed(0, 1'b1);
        while (ev_seen[0] == 0) @(posedge sys_clk);
        repeat (12) @(posedge sys_clk);  // words still offered to the idle channel
        feed(0, 1'b0);
        wait_drained();
        check_value("events", 1, ev_seen[0]);
        check_value("words written", m_size[0] / 4, wr_cnt[0]);
        apb_access(1'b0, 8, 0);
        check_value("REG_CFG enable", 0, 32'(rdata[4]));
        end_test();

        test_name = "cont";
        set_cfg(1, 32'h11);
        feed(1, 1'b1);
        while (ev_seen[1] < 3) @(posedge sys_clk);
        feed(1, 1'b0);
        wait_drained();
        check_value("events", 3, ev_seen[1]);
        set_cfg(1, 32'h20);
        end_test();

        test_name = "dual";
        clear_counts();
        program_channel(0, 32);
        program_channel(1, 32);
        @(negedge sys_clk);
        gaps_on   = 1'b1;
        stalls_on = 1'b1;
        set_cfg(0, 32'h10);
        set_cfg(1, 32'h10);
        feed(0, 1'b1);
        feed(1, 1'b1);
        while (ev_seen[0] == 0 || ev_seen[1] == 0) @(posedge sys_clk);
        feed(0, 1'b0);
        feed(1, 1'b0);
        wait_drained();
        for (int c = 0; c < NCH; c++) begin
            check_value("events", 1, ev_seen[c]);
            check_value("words written", m_size[c] / 4, wr_cnt[c]);
        end
        end_test();

        test_name = "clear";
        clear_counts();
        program_channel(0, 32);
        set_cfg(0, 32'h10);
        feed(0, 1'b1);
        while (acc_cnt[0] < 6) @(posedge sys_clk);
        set_cfg(0, 32'h20);
        repeat (20) @(posedge sys_clk);
        feed(0, 1'b0);
        wait_drained();
        check_value("events", 0, ev_seen[0]);
        apb_access(1'b0, 4, 0);
        check_value("REG_SIZE", 0, rdata);
        apb_access(1'b0, 8, 0);
        check_value("REG_CFG enable", 0, 32'(rdata[4]));
        end_test();

        $display("summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: udma_rx_subsystem.f
+incdir+verification
verilog/udma_rx_pkg.sv
verilog/udma_rx_apb_regs.sv
verilog/udma_rx_channel.sv
verilog/udma_rx_arbiter.sv
verilog/udma_rx_l2_port.sv
verilog/udma_rx_subsystem.sv
verification/tb_udma_rx_subsystem.sv

// File: Bender.yml
package:
  name: udma_rx_subsystem

sources:
  - verilog/udma_rx_pkg.sv
  - verilog/udma_rx_apb_regs.sv
  - verilog/udma_rx_channel.sv
  - verilog/udma_rx_arbiter.sv
  - verilog/udma_rx_l2_port.sv
  - verilog/udma_rx_subsystem.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_udma_rx_subsystem.sv
